// File: include/status_mem_config.svh
// sizing macros for the neuron core status memory
// neuron and axon index widths, word widths, weight fifo depth

`ifndef STATUS_MEM_CONFIG_SVH
`define STATUS_MEM_CONFIG_SVH

// 256 neurons per core
`define STATUS_NURN_AW 8

// 256 axons per neuron
`define STATUS_AXON_AW 8

// bias, potential, threshold and weight words
`define STATUS_DSIZE 16

// pre and post spike history window
`define STATUS_HIST_W 8

// 512 deep, so a second neuron's recall still fits
// while the first neuron has not started learning
`define STATUS_FIFO_AW 9

`endif

// File: design/status_mem_pkg.sv
// shared word and address types of the status memory
// state words, spike history words, neuron and synapse addresses

`include "status_mem_config.svh"

package status_mem_pkg;

	// bias, membrane potential, threshold or synaptic weight
	typedef logic [`STATUS_DSIZE-1:0] state_word_t;

	// pre or post spike history
	typedef logic [`STATUS_HIST_W-1:0] hist_t;

	// plain neuron index
	typedef logic [`STATUS_NURN_AW-1:0] nurn_addr_t;

	// neuron index in the upper bits, axon index in the lower bits
	typedef logic [`STATUS_NURN_AW+`STATUS_AXON_AW-1:0] syn_addr_t;

endpackage

// File: design/status_ram.sv
// single memory with synchronous write port and
// a read port behind a registered read address

`timescale 1ns/100ps

`include "status_mem_config.svh"

module status_ram
#(
	parameter type word_t = status_mem_pkg::state_word_t,
	parameter int ADDR_W = `STATUS_NURN_AW
)
(
	input  logic              clk_i,
	input  logic              rd_en_i,
	input  logic [ADDR_W-1:0] rd_addr_i,
	input  logic              wr_en_i,
	input  logic [ADDR_W-1:0] wr_addr_i,
	input  word_t             wr_data_i,
	output word_t             rd_data_o
);

	word_t             mem [0:(1<<ADDR_W)-1];
	logic [ADDR_W-1:0] rd_addr_q;

	always_ff @(posedge clk_i)
	begin
		if (wr_en_i)
		begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// address is held until the next read enable
	always_ff @(posedge clk_i)
	begin
		if (rd_en_i)
		begin
			rd_addr_q <= rd_addr_i;
		end
	end

	// output tracks later writes to the held address
	assign rd_data_o = mem[rd_addr_q];

	a_wr_addr_known: assert property (
		@(posedge clk_i) wr_en_i |-> !$isunknown(wr_addr_i)
	) else $error("status_ram: write with unknown address");

endmodule

// File: design/neuron_state_mem.sv
// per-neuron state memories of the core
// bias, membrane potential, threshold and post spike history
// one shared read address, one shared write address

`timescale 1ns/100ps

module neuron_state_mem
(
	input  logic                      clk_i,

	// read side, one enable per field
	input  status_mem_pkg::nurn_addr_t  rd_addr_i,
	input  logic                        rd_en_bias_i,
	input  logic                        rd_en_potential_i,
	input  logic                        rd_en_threshold_i,
	input  logic                        rd_en_posthist_i,

	// write side
	input  status_mem_pkg::nurn_addr_t  wr_addr_i,
	input  status_mem_pkg::state_word_t wr_bias_i,
	input  status_mem_pkg::state_word_t wr_potential_i,
	input  status_mem_pkg::state_word_t wr_threshold_i,
	input  status_mem_pkg::hist_t       wr_posthist_i,
	input  logic                        wr_en_bias_i,
	input  logic                        wr_en_potential_i,
	input  logic                        wr_en_threshold_i,
	input  logic                        wr_en_posthist_i,

	output status_mem_pkg::state_word_t rd_bias_o,
	output status_mem_pkg::state_word_t rd_potential_o,
	output status_mem_pkg::state_word_t rd_threshold_o,
	output status_mem_pkg::hist_t       rd_posthist_o
);

	localparam int NURN_AW = $bits(status_mem_pkg::nurn_addr_t);

	status_ram #(.word_t(status_mem_pkg::state_word_t), .ADDR_W(NURN_AW)) u_bias (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_bias_i),
		.rd_addr_i (rd_addr_i),
		.wr_en_i   (wr_en_bias_i),
		.wr_addr_i (wr_addr_i),
		.wr_data_i (wr_bias_i),
		.rd_data_o (rd_bias_o)
	);

	status_ram #(.word_t(status_mem_pkg::state_word_t), .ADDR_W(NURN_AW)) u_potential (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_potential_i),
		.rd_addr_i (rd_addr_i),
		.wr_en_i   (wr_en_potential_i),
		.wr_addr_i (wr_addr_i),
		.wr_data_i (wr_potential_i),
		.rd_data_o (rd_potential_o)
	);

	status_ram #(.word_t(status_mem_pkg::state_word_t), .ADDR_W(NURN_AW)) u_threshold (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_threshold_i),
		.rd_addr_i (rd_addr_i),
		.wr_en_i   (wr_en_threshold_i),
		.wr_addr_i (wr_addr_i),
		.wr_data_i (wr_threshold_i),
		.rd_data_o (rd_threshold_o)
	);

	// history words are narrower
	status_ram #(.word_t(status_mem_pkg::hist_t), .ADDR_W(NURN_AW)) u_posthist (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_posthist_i),
		.rd_addr_i (rd_addr_i),
		.wr_en_i   (wr_en_posthist_i),
		.wr_addr_i (wr_addr_i),
		.wr_data_i (wr_posthist_i),
		.rd_data_o (rd_posthist_o)
	);

endmodule

// File: design/synapse_mem.sv
// per-synapse memories of the core
// pre spike history on ports C and D, weight on ports E and G
// valid flag that marks a weight read

`timescale 1ns/100ps

module synapse_mem
(
	input  logic                        clk_i,
	input  logic                        rst_n_i,

	// port C, pre history read
	input  status_mem_pkg::syn_addr_t   prehist_rd_addr_i,
	input  logic                        prehist_rd_en_i,

	// port D, pre history write
	input  status_mem_pkg::syn_addr_t   prehist_wr_addr_i,
	input  logic                        prehist_wr_en_i,
	input  status_mem_pkg::hist_t       prehist_wr_data_i,

	output status_mem_pkg::hist_t       prehist_rd_data_o,

	// port E, weight read
	input  status_mem_pkg::syn_addr_t   weight_rd_addr_i,
	input  logic                        weight_rd_en_i,

	// port G, weight write
	input  status_mem_pkg::syn_addr_t   weight_wr_addr_i,
	input  logic                        weight_wr_en_i,
	input  status_mem_pkg::state_word_t weight_wr_data_i,

	output status_mem_pkg::state_word_t weight_rd_data_o,
	output logic                        weight_rd_valid_o
);

	localparam int SYN_AW = $bits(status_mem_pkg::syn_addr_t);

	logic weight_rd_valid_q;

	status_ram #(.word_t(status_mem_pkg::hist_t), .ADDR_W(SYN_AW)) u_prehist (
		.clk_i     (clk_i),
		.rd_en_i   (prehist_rd_en_i),
		.rd_addr_i (prehist_rd_addr_i),
		.wr_en_i   (prehist_wr_en_i),
		.wr_addr_i (prehist_wr_addr_i),
		.wr_data_i (prehist_wr_data_i),
		.rd_data_o (prehist_rd_data_o)
	);

	status_ram #(.word_t(status_mem_pkg::state_word_t), .ADDR_W(SYN_AW)) u_weight (
		.clk_i     (clk_i),
		.rd_en_i   (weight_rd_en_i),
		.rd_addr_i (weight_rd_addr_i),
		.wr_en_i   (weight_wr_en_i),
		.wr_addr_i (weight_wr_addr_i),
		.wr_data_i (weight_wr_data_i),
		.rd_data_o (weight_rd_data_o)
	);

	// flag rises on the same edge that loads the weight address
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			weight_rd_valid_q <= 1'b0;
		end
		else
		begin
			weight_rd_valid_q <= weight_rd_en_i;
		end
	end

	assign weight_rd_valid_o = weight_rd_valid_q;

endmodule

// File: design/weight_fifo.sv
// single clock show-ahead fifo for prefetched weights
// circular buffer with fill count, synchronous clear per time step
// empty and full flags

`timescale 1ns/100ps

`include "status_mem_config.svh"

module weight_fifo
#(
	parameter int ADDR_W = `STATUS_FIFO_AW
)
(
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic                        clr_i,
	input  logic                        wr_en_i,
	input  status_mem_pkg::state_word_t wr_data_i,
	input  logic                        rd_en_i,
	output status_mem_pkg::state_word_t rd_data_o,
	output logic                        empty_o,
	output logic                        full_o
);

	localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

	status_mem_pkg::state_word_t buf_mem [0:(1<<ADDR_W)-1];

	logic [ADDR_W-1:0] wr_ptr_q;
	logic [ADDR_W-1:0] rd_ptr_q;
	logic [ADDR_W:0]   count_q;
	logic              wr_ok;
	logic              rd_ok;

	// drop writes when full, ignore pops when empty
	assign wr_ok = wr_en_i && !full_o;
	assign rd_ok = rd_en_i && !empty_o;

	always_ff @(posedge clk_i)
	begin
		if (wr_ok)
		begin
			buf_mem[wr_ptr_q] <= wr_data_i;
		end
	end

	// clear wins over a write or pop on the same edge
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else if (clr_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (wr_ok)
			begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (rd_ok)
			begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			if (wr_ok && !rd_ok)
			begin
				count_q <= count_q + 1'b1;
			end
			else if (rd_ok && !wr_ok)
			begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// head word is visible without a read request
	assign rd_data_o = buf_mem[rd_ptr_q];
	assign empty_o   = (count_q == '0);
	assign full_o    = (count_q == DEPTH);

	a_no_write_full: assert property (
		@(posedge clk_i) disable iff (!rst_n_i) (wr_en_i && !clr_i) |-> !full_o
	) else $warning("weight_fifo: write while full, weight dropped");

	a_no_read_empty: assert property (
		@(posedge clk_i) disable iff (!rst_n_i) (rd_en_i && !clr_i) |-> !empty_o
	) else $warning("weight_fifo: pop while empty, ignored");

endmodule

// File: design/status_mem_top.sv
// status memory of one spiking neuron core
// neuron state memories, synapse memories and the weight prefetch fifo

`timescale 1ns/100ps

module status_mem_top
(
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic                        start_i,

	// neuron state, port A read
	input  status_mem_pkg::nurn_addr_t  rd_addr_i,
	input  logic                        rd_en_bias_i,
	input  logic                        rd_en_potential_i,
	input  logic                        rd_en_threshold_i,
	input  logic                        rd_en_posthist_i,

	// neuron state, port B write
	input  status_mem_pkg::nurn_addr_t  wr_addr_i,
	input  status_mem_pkg::state_word_t wr_bias_i,
	input  status_mem_pkg::state_word_t wr_potential_i,
	input  status_mem_pkg::state_word_t wr_threshold_i,
	input  status_mem_pkg::hist_t       wr_posthist_i,
	input  logic                        wr_en_bias_i,
	input  logic                        wr_en_potential_i,
	input  logic                        wr_en_threshold_i,
	input  logic                        wr_en_posthist_i,

	output status_mem_pkg::state_word_t rd_bias_o,
	output status_mem_pkg::state_word_t rd_potential_o,
	output status_mem_pkg::state_word_t rd_threshold_o,
	output status_mem_pkg::hist_t       rd_posthist_o,

	// synapse ports C, D, E and G
	input  status_mem_pkg::syn_addr_t   prehist_rd_addr_i,
	input  logic                        prehist_rd_en_i,
	input  status_mem_pkg::syn_addr_t   prehist_wr_addr_i,
	input  logic                        prehist_wr_en_i,
	input  status_mem_pkg::hist_t       prehist_wr_data_i,
	output status_mem_pkg::hist_t       prehist_rd_data_o,
	input  status_mem_pkg::syn_addr_t   weight_rd_addr_i,
	input  logic                        weight_rd_en_i,
	input  status_mem_pkg::syn_addr_t   weight_wr_addr_i,
	input  logic                        weight_wr_en_i,
	input  status_mem_pkg::state_word_t weight_wr_data_i,
	output status_mem_pkg::state_word_t weight_rd_data_o,

	// learning side of the weight fifo
	input  logic                        fifo_rd_en_i,
	output status_mem_pkg::state_word_t fifo_data_o,
	output logic                        fifo_empty_o,
	output logic                        fifo_full_o
);

	logic weight_rd_valid;

	neuron_state_mem u_neuron_state_mem (
		.clk_i             (clk_i),
		.rd_addr_i         (rd_addr_i),
		.rd_en_bias_i      (rd_en_bias_i),
		.rd_en_potential_i (rd_en_potential_i),
		.rd_en_threshold_i (rd_en_threshold_i),
		.rd_en_posthist_i  (rd_en_posthist_i),
		.wr_addr_i         (wr_addr_i),
		.wr_bias_i         (wr_bias_i),
		.wr_potential_i    (wr_potential_i),
		.wr_threshold_i    (wr_threshold_i),
		.wr_posthist_i     (wr_posthist_i),
		.wr_en_bias_i      (wr_en_bias_i),
		.wr_en_potential_i (wr_en_potential_i),
		.wr_en_threshold_i (wr_en_threshold_i),
		.wr_en_posthist_i  (wr_en_posthist_i),
		.rd_bias_o         (rd_bias_o),
		.rd_potential_o    (rd_potential_o),
		.rd_threshold_o    (rd_threshold_o),
		.rd_posthist_o     (rd_posthist_o)
	);

	synapse_mem u_synapse_mem (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.prehist_rd_addr_i (prehist_rd_addr_i),
		.prehist_rd_en_i   (prehist_rd_en_i),
		.prehist_wr_addr_i (prehist_wr_addr_i),
		.prehist_wr_en_i   (prehist_wr_en_i),
		.prehist_wr_data_i (prehist_wr_data_i),
		.prehist_rd_data_o (prehist_rd_data_o),
		.weight_rd_addr_i  (weight_rd_addr_i),
		.weight_rd_en_i    (weight_rd_en_i),
		.weight_wr_addr_i  (weight_wr_addr_i),
		.weight_wr_en_i    (weight_wr_en_i),
		.weight_wr_data_i  (weight_wr_data_i),
		.weight_rd_data_o  (weight_rd_data_o),
		.weight_rd_valid_o (weight_rd_valid)
	);

	// every weight read is queued for learning, cleared each time step
	weight_fifo u_weight_fifo (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.clr_i     (start_i),
		.wr_en_i   (weight_rd_valid),
		.wr_data_i (weight_rd_data_o),
		.rd_en_i   (fifo_rd_en_i),
		.rd_data_o (fifo_data_o),
		.empty_o   (fifo_empty_o),
		.full_o    (fifo_full_o)
	);

endmodule

// File: testbench/tb_clock_gen.sv
// clock and reset source for the status memory testbench
// 8 ns clock, active low reset held for 8 cycles

`timescale 1ns/100ps

module tb_clock_gen
(
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
		begin
			#4 clk_o = ~clk_o;
		end
	end

	// release just after the 8th rising edge
	initial
	begin
		rst_n_o = 1'b0;
		repeat (8)
		begin
			@(posedge clk_o);
		end
		#1 rst_n_o = 1'b1;
	end

endmodule

// File: testbench/tb_status_mem.sv
// testbench for the neuron core status memory
// directed tests for neuron state, synapse memories and the weight fifo
// reference arrays for every memory, a queue for the fifo

`timescale 1ns/100ps

`include "status_mem_config.svh"

module tb_status_mem;

	localparam int FIFO_DEPTH = 1 << `STATUS_FIFO_AW;

	logic clk;
	logic rst_n;
	logic start;

	status_mem_pkg::nurn_addr_t  rd_addr;
	logic                        rd_en_bias, rd_en_potential, rd_en_threshold, rd_en_posthist;
	status_mem_pkg::nurn_addr_t  wr_addr;
	status_mem_pkg::state_word_t wr_bias, wr_potential, wr_threshold;
	status_mem_pkg::hist_t       wr_posthist;
	logic                        wr_en_bias, wr_en_potential, wr_en_threshold, wr_en_posthist;
	status_mem_pkg::state_word_t rd_bias, rd_potential, rd_threshold;
	status_mem_pkg::hist_t       rd_posthist;

	status_mem_pkg::syn_addr_t   prehist_rd_addr, prehist_wr_addr;
	logic                        prehist_rd_en, prehist_wr_en;
	status_mem_pkg::hist_t       prehist_wr_data, prehist_rd_data;
	status_mem_pkg::syn_addr_t   weight_rd_addr, weight_wr_addr;
	logic                        weight_rd_en, weight_wr_en;
	status_mem_pkg::state_word_t weight_wr_data, weight_rd_data;

	logic                        fifo_rd_en;
	status_mem_pkg::state_word_t fifo_data;
	logic                        fifo_empty, fifo_full;

	// reference contents
	status_mem_pkg::state_word_t bias_model [0:255];
	status_mem_pkg::state_word_t potential_model [0:255];
	status_mem_pkg::state_word_t threshold_model [0:255];
	status_mem_pkg::hist_t       posthist_model [0:255];
	status_mem_pkg::hist_t       prehist_model [0:65535];
	status_mem_pkg::state_word_t weight_model [0:65535];
	status_mem_pkg::state_word_t fifo_model [$];

	int test_errs;
	int tests_passed;
	int tests_failed;

	tb_clock_gen u_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

	status_mem_top DUT (
		.clk_i (clk), .rst_n_i (rst_n), .start_i (start),
		.rd_addr_i (rd_addr), .rd_en_bias_i (rd_en_bias),
		.rd_en_potential_i (rd_en_potential), .rd_en_threshold_i (rd_en_threshold),
		.rd_en_posthist_i (rd_en_posthist), .wr_addr_i (wr_addr),
		.wr_bias_i (wr_bias), .wr_potential_i (wr_potential),
		.wr_threshold_i (wr_threshold), .wr_posthist_i (wr_posthist),
		.wr_en_bias_i (wr_en_bias), .wr_en_potential_i (wr_en_potential),
		.wr_en_threshold_i (wr_en_threshold), .wr_en_posthist_i (wr_en_posthist),
		.rd_bias_o (rd_bias), .rd_potential_o (rd_potential),
		.rd_threshold_o (rd_threshold), .rd_posthist_o (rd_posthist),
		.prehist_rd_addr_i (prehist_rd_addr), .prehist_rd_en_i (prehist_rd_en),
		.prehist_wr_addr_i (prehist_wr_addr), .prehist_wr_en_i (prehist_wr_en),
		.prehist_wr_data_i (prehist_wr_data), .prehist_rd_data_o (prehist_rd_data),
		.weight_rd_addr_i (weight_rd_addr), .weight_rd_en_i (weight_rd_en),
		.weight_wr_addr_i (weight_wr_addr), .weight_wr_en_i (weight_wr_en),
		.weight_wr_data_i (weight_wr_data), .weight_rd_data_o (weight_rd_data),
		.fifo_rd_en_i (fifo_rd_en), .fifo_data_o (fifo_data),
		.fifo_empty_o (fifo_empty), .fifo_full_o (fifo_full)
	);

	// inputs change 1 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic init_inputs();
		start = 1'b0;
		rd_addr = '0;
		{rd_en_bias, rd_en_potential, rd_en_threshold, rd_en_posthist} = 4'b0000;
		wr_addr = '0;
		wr_bias = '0;
		wr_potential = '0;
		wr_threshold = '0;
		wr_posthist = '0;
		{wr_en_bias, wr_en_potential, wr_en_threshold, wr_en_posthist} = 4'b0000;
		prehist_rd_addr = '0;
		prehist_rd_en = 1'b0;
		prehist_wr_addr = '0;
		prehist_wr_en = 1'b0;
		prehist_wr_data = '0;
		weight_rd_addr = '0;
		weight_rd_en = 1'b0;
		weight_wr_addr = '0;
		weight_wr_en = 1'b0;
		weight_wr_data = '0;
		fifo_rd_en = 1'b0;
	endtask

	task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0)
		begin
			$display("%s: ok", name);
			tests_passed++;
		end
		else
		begin
			$display("%s: failed with %0d errors", name, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	// mixes both address bytes so neighbouring words differ
	function automatic status_mem_pkg::state_word_t weight_pattern(
		input status_mem_pkg::syn_addr_t a);
		return {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	// fifo model drops a word when full
	task automatic queue_weight(input status_mem_pkg::syn_addr_t a);
		if (fifo_model.size() < FIFO_DEPTH)
		begin
			fifo_model.push_back(weight_model[a]);
		end
	endtask

	task automatic wait_reset_release(input int max_cycles);
		int n;
		n = 0;
		while (!rst_n && n < max_cycles)
		begin
			@(posedge clk);
			n++;
		end
		#1;
		if (!rst_n)
		begin
			$display("reset was never released");
			tests_failed++;
		end
	endtask

	task automatic wait_fifo_filled(input int max_cycles);
		int n;
		n = 0;
		while (fifo_empty && n < max_cycles)
		begin
			tick();
			n++;
		end
		if (fifo_empty)
		begin
			$display("timed out waiting for the weight fifo to receive data");
			test_errs++;
		end
	endtask

	task automatic wait_fifo_full(input int max_cycles);
		int n;
		n = 0;
		while (!fifo_full && n < max_cycles)
		begin
			tick();
			n++;
		end
		if (!fifo_full)
		begin
			$display("timed out waiting for the weight fifo to fill up");
			test_errs++;
		end
	endtask

	task automatic clear_fifo();
		start = 1'b1;
		tick();
		start = 1'b0;
		fifo_model.delete();
		check_flag("fifo empty after start", fifo_empty, 1'b1);
	endtask

	task automatic write_neuron(input status_mem_pkg::nurn_addr_t a,
		input status_mem_pkg::state_word_t b, input status_mem_pkg::state_word_t p,
		input status_mem_pkg::state_word_t t, input status_mem_pkg::hist_t h);
		wr_addr = a;
		wr_bias = b;
		wr_potential = p;
		wr_threshold = t;
		wr_posthist = h;
		{wr_en_bias, wr_en_potential, wr_en_threshold, wr_en_posthist} = 4'b1111;
		bias_model[a] = b;
		potential_model[a] = p;
		threshold_model[a] = t;
		posthist_model[a] = h;
		tick();
		{wr_en_bias, wr_en_potential, wr_en_threshold, wr_en_posthist} = 4'b0000;
	endtask

	task automatic read_neuron(input status_mem_pkg::nurn_addr_t a);
		rd_addr = a;
		{rd_en_bias, rd_en_potential, rd_en_threshold, rd_en_posthist} = 4'b1111;
		tick();
		{rd_en_bias, rd_en_potential, rd_en_threshold, rd_en_posthist} = 4'b0000;
		check_word("bias", rd_bias, bias_model[a]);
		check_word("potential", rd_potential, potential_model[a]);
		check_word("threshold", rd_threshold, threshold_model[a]);
		check_word("post history", 16'(rd_posthist), 16'(posthist_model[a]));
	endtask

	task automatic write_weight(input status_mem_pkg::syn_addr_t a,
		input status_mem_pkg::state_word_t w);
		weight_wr_addr = a;
		weight_wr_data = w;
		weight_wr_en = 1'b1;
		weight_model[a] = w;
		tick();
		weight_wr_en = 1'b0;
	endtask

	task automatic test_neuron_roundtrip();
		status_mem_pkg::nurn_addr_t idx [0:15];
		int i;
		for (i = 0; i < 16; i++)
		begin
			idx[i] = 8'($urandom);
			write_neuron(idx[i], 16'($urandom), 16'($urandom), 16'($urandom), 8'($urandom));
		end
		for (i = 0; i < 16; i++)
		begin
			read_neuron(idx[i]);
		end
		finish_test("test 1 neuron state round-trip");
	endtask

	task automatic test_read_hold();
		status_mem_pkg::nurn_addr_t  a;
		status_mem_pkg::nurn_addr_t  b;
		status_mem_pkg::state_word_t held;
		a = 8'($urandom);
		b = a + 8'd1;
		write_neuron(a, 16'($urandom), 16'($urandom), 16'($urandom), 8'($urandom));
		write_neuron(b, 16'($urandom), 16'($urandom), 16'($urandom), 8'($urandom));
		rd_addr = a;
		rd_en_bias = 1'b1;
		tick();
		rd_en_bias = 1'b0;
		held = bias_model[a];
		check_word("bias before hold", rd_bias, held);
		// other fields move to b, bias keeps a
		rd_addr = b;
		{rd_en_potential, rd_en_threshold, rd_en_posthist} = 3'b111;
		tick();
		{rd_en_potential, rd_en_threshold, rd_en_posthist} = 3'b000;
		check_word("held bias", rd_bias, held);
		check_word("potential", rd_potential, potential_model[b]);
		check_word("threshold", rd_threshold, threshold_model[b]);
		check_word("post history", 16'(rd_posthist), 16'(posthist_model[b]));
		wr_addr = a;
		wr_bias = ~held;
		wr_en_bias = 1'b1;
		bias_model[a] = ~held;
		tick();
		wr_en_bias = 1'b0;
		check_word("bias after write", rd_bias, bias_model[a]);
		finish_test("test 2 read-address hold");
	endtask

	task automatic test_synapse_roundtrip();
		status_mem_pkg::syn_addr_t addrs [0:9];
		int i;
		addrs[0] = {8'hff, 8'($urandom)};
		addrs[1] = {8'($urandom), 8'hff};
		addrs[2] = 16'hffff;
		for (i = 3; i < 10; i++)
		begin
			addrs[i] = 16'($urandom);
		end
		// pre history and weight go to different synapses in the same cycle
		for (i = 0; i < 10; i++)
		begin
			prehist_wr_addr = addrs[i];
			prehist_wr_data = 8'($urandom);
			prehist_wr_en = 1'b1;
			prehist_model[addrs[i]] = prehist_wr_data;
			write_weight(addrs[9 - i], 16'($urandom));
			prehist_wr_en = 1'b0;
		end
		for (i = 0; i < 10; i++)
		begin
			prehist_rd_addr = addrs[i];
			weight_rd_addr = addrs[9 - i];
			prehist_rd_en = 1'b1;
			weight_rd_en = 1'b1;
			queue_weight(addrs[9 - i]);
			tick();
			prehist_rd_en = 1'b0;
			weight_rd_en = 1'b0;
			check_word("pre history", 16'(prehist_rd_data), 16'(prehist_model[addrs[i]]));
			check_word("weight", weight_rd_data, weight_model[addrs[9 - i]]);
		end
		finish_test("test 3 synapse round-trip");
	endtask

	task automatic test_prefetch_order();
		int i;
		clear_fifo();
		for (i = 0; i < 20; i++)
		begin
			write_weight(16'h1200 + 16'(i), weight_pattern(16'h1200 + 16'(i)));
		end
		for (i = 0; i < 20; i++)
		begin
			weight_rd_addr = 16'h1200 + 16'(i);
			weight_rd_en = 1'b1;
			queue_weight(weight_rd_addr);
			tick();
		end
		weight_rd_en = 1'b0;
		wait_fifo_filled(8);
		for (i = 0; i < 20; i++)
		begin
			check_flag("fifo empty during drain", fifo_empty, 1'b0);
			check_word("fifo head", fifo_data, fifo_model.pop_front());
			fifo_rd_en = 1'b1;
			tick();
		end
		fifo_rd_en = 1'b0;
		check_flag("fifo empty after drain", fifo_empty, 1'b1);
		finish_test("test 4 weight prefetch order");
	endtask

	task automatic test_clear_full();
		int i;
		int pops;
		clear_fifo();
		for (i = 0; i <= FIFO_DEPTH; i++)
		begin
			write_weight(16'h4000 + 16'(i), weight_pattern(16'h4000 + 16'(i)));
		end
		for (i = 0; i < FIFO_DEPTH; i++)
		begin
			weight_rd_addr = 16'h4000 + 16'(i);
			weight_rd_en = 1'b1;
			queue_weight(weight_rd_addr);
			tick();
		end
		weight_rd_en = 1'b0;
		wait_fifo_full(8);
		// one read too many, its word must be dropped
		weight_rd_addr = 16'h4000 + 16'(FIFO_DEPTH);
		weight_rd_en = 1'b1;
		queue_weight(weight_rd_addr);
		tick();
		weight_rd_en = 1'b0;
		tick();
		tick();
		check_flag("fifo full after extra read", fifo_full, 1'b1);
		pops = 0;
		while (!fifo_empty && fifo_model.size() > 0 && pops < FIFO_DEPTH + 8)
		begin
			check_word("fifo head", fifo_data, fifo_model.pop_front());
			fifo_rd_en = 1'b1;
			tick();
			pops++;
			if (pops == 1)
			begin
				check_flag("fifo full after one pop", fifo_full, 1'b0);
			end
		end
		fifo_rd_en = 1'b0;
		if (pops != FIFO_DEPTH || !fifo_empty)
		begin
			$display("error at %0t ns: fifo gave %0d words, expected %0d", $time, pops,
				FIFO_DEPTH);
			test_errs++;
		end
		// refill a little, then start a new time step
		for (i = 0; i < 3; i++)
		begin
			weight_rd_addr = 16'h4000 + 16'(i);
			weight_rd_en = 1'b1;
			queue_weight(weight_rd_addr);
			tick();
		end
		weight_rd_en = 1'b0;
		wait_fifo_filled(8);
		clear_fifo();
		finish_test("test 5 clear and full");
	endtask

	initial
	begin
		void'($urandom(22007));
		test_errs = 0;
		tests_passed = 0;
		tests_failed = 0;
		init_inputs();
		wait_reset_release(20);
		check_flag("fifo empty after reset", fifo_empty, 1'b1);
		check_flag("fifo full after reset", fifo_full, 1'b0);
		finish_test("reset state");
		test_neuron_roundtrip();
		test_read_hold();
		test_synapse_roundtrip();
		test_prefetch_order();
		test_clear_full();
		$display("summary: %0d ok, %0d failed", tests_passed, tests_failed);
		if (tests_failed == 0)
		begin
			$display("All tests passed");
		end
		else
		begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+include
design/status_mem_pkg.sv
design/status_ram.sv
design/neuron_state_mem.sv
design/synapse_mem.sv
design/weight_fifo.sv
design/status_mem_top.sv
testbench/tb_clock_gen.sv
testbench/tb_status_mem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0
TOP       := tb_status_mem
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
